/* src/alu_pkg.sv */
// Fixed four-lane 32-bit configuration; tags are not checked for uniqueness while in flight
package alu_pkg;

    // Lane count and per-lane data width of one warp request
    localparam int num_lanes  = 4;
    localparam int xlen       = 32;

    // Sideband widths
    localparam int tag_width  = 8;
    localparam int wid_width  = 4;
    localparam int reg_bits   = 5;

    // Shift amount and divider iteration counter width
    localparam int shamt_bits = $clog2(xlen);

    // Encodings are fixed so that vector files can use plain opcode numbers
    typedef enum logic [4:0] {
        op_add  = 5'd0,
        op_sub  = 5'd1,
        op_and  = 5'd2,
        op_or   = 5'd3,
        op_xor  = 5'd4,
        op_sll  = 5'd5,
        op_srl  = 5'd6,
        op_sra  = 5'd7,
        op_slt  = 5'd8,
        op_sltu = 5'd9,
        op_beq  = 5'd10,
        op_bne  = 5'd11,
        op_blt  = 5'd12,
        op_bge  = 5'd13,
        op_mul  = 5'd14,
        op_mulh = 5'd15,
        op_div  = 5'd16,
        op_rem  = 5'd17
    } alu_op_e;

    // One warp's worth of operands entering the execute stage
    typedef struct packed {
        logic [tag_width-1:0]           tag;
        logic [wid_width-1:0]           wid;
        logic [num_lanes-1:0]           tmask;
        alu_op_e                        op;
        logic [reg_bits-1:0]            rd;
        logic [xlen-1:0]                pc;
        logic [xlen-1:0]                imm;
        logic [num_lanes-1:0][xlen-1:0] rs1;
        logic [num_lanes-1:0][xlen-1:0] rs2;
    } alu_req_t;

    // Result headed for the register file; wb is low for branches
    typedef struct packed {
        logic [tag_width-1:0]           tag;
        logic [wid_width-1:0]           wid;
        logic [num_lanes-1:0]           tmask;
        logic [reg_bits-1:0]            rd;
        logic                           wb;
        logic [num_lanes-1:0][xlen-1:0] data;
    } alu_commit_t;

    // Branch resolution sent back to the warp scheduler
    typedef struct packed {
        logic [wid_width-1:0] wid;
        logic                 taken;
        logic [xlen-1:0]      target;
    } branch_ctl_t;

endpackage

/* src/alu_dispatch.sv */
// Single-entry skid-free input register; exactly one unit valid is raised per request
`timescale 1ns/100ps

module alu_dispatch (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              in_valid,
    output logic              in_ready,
    input  alu_pkg::alu_req_t in_req,
    output logic              int_valid,
    input  logic              int_ready,
    output logic              mdv_valid,
    input  logic              mdv_ready,
    output alu_pkg::alu_req_t out_req
);
    import alu_pkg::*;

    logic full;
    logic is_mdv_q;
    logic in_is_mdv;
    logic out_fire;

    // Opcode class is decided on the way in so the output side only sees a flag
    assign in_is_mdv = in_req.op inside {op_mul, op_mulh, op_div, op_rem};

    assign int_valid = full && !is_mdv_q;
    assign mdv_valid = full && is_mdv_q;

    // The entry leaves when the unit it was steered to takes it
    assign out_fire = (int_valid && int_ready) || (mdv_valid && mdv_ready);

    // Accept when empty or when the current entry is leaving this cycle
    assign in_ready = !full || out_fire;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            full <= 1'b0;
        end else if (in_ready) begin
            full <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            out_req  <= in_req;
            is_mdv_q <= in_is_mdv;
        end
    end

endmodule

/* src/alu_int_unit.sv */
// Two-stage integer and branch pipeline; any output stall freezes both stages together
`timescale 1ns/100ps

module alu_int_unit (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 in_valid,
    output logic                 in_ready,
    input  alu_pkg::alu_req_t    in_req,
    output logic                 out_valid,
    input  logic                 out_ready,
    output alu_pkg::alu_commit_t out_data,
    output logic                 branch_valid,
    output alu_pkg::branch_ctl_t branch_ctl
);
    import alu_pkg::*;

    logic                           s1_valid;
    alu_req_t                       s1_req;
    logic                           s2_valid;
    alu_commit_t                    s2_data;
    logic                           stall;
    logic                           is_branch;
    logic [num_lanes-1:0][xlen-1:0] lane_res;
    logic [xlen-1:0]                br_a;
    logic [xlen-1:0]                br_b;
    logic                           br_taken;

    assign stall     = s2_valid && !out_ready;
    assign in_ready  = !stall;
    assign is_branch = s1_req.op inside {op_beq, op_bne, op_blt, op_bge};

    // Stage 1 lane arithmetic
    always_comb begin
        for (int i = 0; i < num_lanes; i++) begin
            case (s1_req.op)
                op_add:  lane_res[i] = s1_req.rs1[i] + s1_req.rs2[i];
                op_sub:  lane_res[i] = s1_req.rs1[i] - s1_req.rs2[i];
                op_and:  lane_res[i] = s1_req.rs1[i] & s1_req.rs2[i];
                op_or:   lane_res[i] = s1_req.rs1[i] | s1_req.rs2[i];
                op_xor:  lane_res[i] = s1_req.rs1[i] ^ s1_req.rs2[i];
                op_sll:  lane_res[i] = s1_req.rs1[i] << s1_req.rs2[i][shamt_bits-1:0];
                op_srl:  lane_res[i] = s1_req.rs1[i] >> s1_req.rs2[i][shamt_bits-1:0];
                op_sra:  lane_res[i] = $signed(s1_req.rs1[i]) >>> s1_req.rs2[i][shamt_bits-1:0];
                op_slt:  lane_res[i] = {{(xlen-1){1'b0}},
                                        $signed(s1_req.rs1[i]) < $signed(s1_req.rs2[i])};
                op_sltu: lane_res[i] = {{(xlen-1){1'b0}}, s1_req.rs1[i] < s1_req.rs2[i]};
                // Branches do not write back
                default: lane_res[i] = '0;
            endcase
        end
    end

    // The lowest active lane decides the branch, scanning downward so it wins
    always_comb begin
        br_a = s1_req.rs1[0];
        br_b = s1_req.rs2[0];
        for (int i = num_lanes - 1; i >= 0; i--) begin
            if (s1_req.tmask[i]) begin
                br_a = s1_req.rs1[i];
                br_b = s1_req.rs2[i];
            end
        end
        case (s1_req.op)
            op_beq:  br_taken = br_a == br_b;
            op_bne:  br_taken = br_a != br_b;
            op_blt:  br_taken = $signed(br_a) < $signed(br_b);
            op_bge:  br_taken = $signed(br_a) >= $signed(br_b);
            default: br_taken = 1'b0;
        endcase
    end

    // Pulse in the same cycle the branch moves into stage 2, so a stall never repeats it
    assign branch_valid      = s1_valid && !stall && is_branch;
    assign branch_ctl.wid    = s1_req.wid;
    assign branch_ctl.taken  = br_taken;
    assign branch_ctl.target = s1_req.pc + s1_req.imm;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else if (!stall) begin
            s1_valid <= in_valid;
            s2_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            if (in_valid) begin
                s1_req <= in_req;
            end
            if (s1_valid) begin
                s2_data.tag   <= s1_req.tag;
                s2_data.wid   <= s1_req.wid;
                s2_data.tmask <= s1_req.tmask;
                s2_data.rd    <= s1_req.rd;
                s2_data.wb    <= !is_branch;
                s2_data.data  <= lane_res;
            end
        end
    end

    assign out_valid = s2_valid;
    assign out_data  = s2_data;

endmodule

/* src/alu_muldiv_unit.sv */
// One request at a time; mul/mulh take two cycles and div/rem take about xlen+1 cycles
`timescale 1ns/100ps

module alu_muldiv_unit (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 in_valid,
    output logic                 in_ready,
    input  alu_pkg::alu_req_t    in_req,
    output logic                 out_valid,
    input  logic                 out_ready,
    output alu_pkg::alu_commit_t out_data
);
    import alu_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_mul,
        st_div,
        st_done
    } state_e;

    state_e                           state;
    logic [shamt_bits-1:0]            count;
    logic                             is_div_op;
    logic [tag_width-1:0]             tag_q;
    logic [wid_width-1:0]             wid_q;
    logic [num_lanes-1:0]             tmask_q;
    logic [reg_bits-1:0]              rd_q;
    alu_op_e                          op_q;

    // Quotient doubles as multiplicand and product, divisor as multiplier
    logic [num_lanes-1:0][xlen-1:0]   quo;
    logic [num_lanes-1:0][xlen-1:0]   rmd;
    logic [num_lanes-1:0][xlen-1:0]   dvs;
    logic [num_lanes-1:0]             neg_q;
    logic [num_lanes-1:0]             neg_r;
    logic [num_lanes-1:0]             dvz;
    logic [num_lanes-1:0][xlen+1:0]   trial;
    logic [num_lanes-1:0][2*xlen-1:0] prod;
    logic [num_lanes-1:0][xlen-1:0]   res;

    assign in_ready  = state == st_idle;
    assign out_valid = state == st_done;
    assign is_div_op = in_req.op inside {op_div, op_rem};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_idle;
            count <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (in_valid) begin
                        state <= is_div_op ? st_div : st_mul;
                        count <= '0;
                    end
                end
                st_mul: state <= st_done;
                st_div: begin
                    count <= count + 1'b1;
                    if (count == shamt_bits'(xlen - 1)) begin
                        state <= st_done;
                    end
                end
                st_done: begin
                    if (out_ready) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_comb begin
        for (int i = 0; i < num_lanes; i++) begin
            prod[i]  = $signed({{xlen{quo[i][xlen-1]}}, quo[i]})
                     * $signed({{xlen{dvs[i][xlen-1]}}, dvs[i]});
            // Extra top bit keeps the borrow visible when the shifted remainder exceeds xlen bits
            trial[i] = {1'b0, rmd[i], quo[i][xlen-1]} - {2'b0, dvs[i]};
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            st_idle: begin
                if (in_valid) begin
                    tag_q   <= in_req.tag;
                    wid_q   <= in_req.wid;
                    tmask_q <= in_req.tmask;
                    rd_q    <= in_req.rd;
                    op_q    <= in_req.op;
                    for (int i = 0; i < num_lanes; i++) begin
                        if (is_div_op) begin
                            // Divide magnitudes and restore signs at the output
                            quo[i]   <= in_req.rs1[i][xlen-1] ? -in_req.rs1[i] : in_req.rs1[i];
                            dvs[i]   <= in_req.rs2[i][xlen-1] ? -in_req.rs2[i] : in_req.rs2[i];
                            rmd[i]   <= '0;
                            neg_q[i] <= in_req.rs1[i][xlen-1] ^ in_req.rs2[i][xlen-1];
                            neg_r[i] <= in_req.rs1[i][xlen-1];
                            dvz[i]   <= in_req.rs2[i] == '0;
                        end else begin
                            quo[i] <= in_req.rs1[i];
                            dvs[i] <= in_req.rs2[i];
                        end
                    end
                end
            end
            st_mul: begin
                for (int i = 0; i < num_lanes; i++) begin
                    quo[i] <= (op_q == op_mulh) ? prod[i][2*xlen-1:xlen] : prod[i][xlen-1:0];
                end
            end
            st_div: begin
                for (int i = 0; i < num_lanes; i++) begin
                    if (!trial[i][xlen+1]) begin
                        rmd[i] <= trial[i][xlen-1:0];
                        quo[i] <= {quo[i][xlen-2:0], 1'b1};
                    end else begin
                        rmd[i] <= {rmd[i][xlen-2:0], quo[i][xlen-1]};
                        quo[i] <= {quo[i][xlen-2:0], 1'b0};
                    end
                end
            end
            default: ;
        endcase
    end

    // Divide by zero leaves the dividend magnitude in rmd, so only the quotient needs forcing
    // The overflow case falls out of the magnitude divide with no special handling
    always_comb begin
        for (int i = 0; i < num_lanes; i++) begin
            case (op_q)
                op_div:  res[i] = dvz[i] ? '1 : (neg_q[i] ? -quo[i] : quo[i]);
                op_rem:  res[i] = neg_r[i] ? -rmd[i] : rmd[i];
                default: res[i] = quo[i];
            endcase
        end
        out_data.tag   = tag_q;
        out_data.wid   = wid_q;
        out_data.tmask = tmask_q;
        out_data.rd    = rd_q;
        out_data.wb    = 1'b1;
        out_data.data  = res;
    end

endmodule

/* src/alu_commit_arb.sv */
// Two-input round-robin merge into one registered entry; adds one cycle of latency
`timescale 1ns/100ps

module alu_commit_arb (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 int_valid,
    output logic                 int_ready,
    input  alu_pkg::alu_commit_t int_data,
    input  logic                 mdv_valid,
    output logic                 mdv_ready,
    input  alu_pkg::alu_commit_t mdv_data,
    output logic                 commit_valid,
    input  logic                 commit_ready,
    output alu_pkg::alu_commit_t commit_data
);
    import alu_pkg::*;

    logic        out_valid_q;
    alu_commit_t out_q;
    logic        load;
    logic        mdv_first;
    logic        grant_int;
    logic        grant_mdv;

    // The output register takes a new entry when it is empty or being drained
    assign load = !out_valid_q || commit_ready;

    assign grant_int = int_valid && (!mdv_valid || !mdv_first);
    assign grant_mdv = mdv_valid && (!int_valid || mdv_first);

    assign int_ready = load && grant_int;
    assign mdv_ready = load && grant_mdv;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid_q <= 1'b0;
            mdv_first   <= 1'b0;
        end else if (load) begin
            out_valid_q <= int_valid || mdv_valid;
            // The loser of this grant is favoured next time
            if (grant_int || grant_mdv) begin
                mdv_first <= grant_int;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (int_ready) begin
            out_q <= int_data;
        end else if (mdv_ready) begin
            out_q <= mdv_data;
        end
    end

    assign commit_valid = out_valid_q;
    assign commit_data  = out_q;

endmodule

/* src/alu_unit.sv */
// Execute stage top; commits may leave out of issue order, so consumers match them by tag
`timescale 1ns/100ps

module alu_unit (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 in_valid,
    output logic                 in_ready,
    input  alu_pkg::alu_req_t    in_req,
    output logic                 commit_valid,
    input  logic                 commit_ready,
    output alu_pkg::alu_commit_t commit_data,
    output logic                 branch_valid,
    output alu_pkg::branch_ctl_t branch_ctl
);
    import alu_pkg::*;

    // Dispatch to the execution units
    alu_req_t    disp_req;
    logic        int_valid;
    logic        int_ready;
    logic        mdv_valid;
    logic        mdv_ready;

    // Unit results to the arbiter
    logic        int_cmt_valid;
    logic        int_cmt_ready;
    alu_commit_t int_cmt_data;
    logic        mdv_cmt_valid;
    logic        mdv_cmt_ready;
    alu_commit_t mdv_cmt_data;

    alu_dispatch dispatch_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_req    (in_req),
        .int_valid (int_valid),
        .int_ready (int_ready),
        .mdv_valid (mdv_valid),
        .mdv_ready (mdv_ready),
        .out_req   (disp_req)
    );

    alu_int_unit int_unit_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_valid     (int_valid),
        .in_ready     (int_ready),
        .in_req       (disp_req),
        .out_valid    (int_cmt_valid),
        .out_ready    (int_cmt_ready),
        .out_data     (int_cmt_data),
        .branch_valid (branch_valid),
        .branch_ctl   (branch_ctl)
    );

    alu_muldiv_unit muldiv_unit_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (mdv_valid),
        .in_ready  (mdv_ready),
        .in_req    (disp_req),
        .out_valid (mdv_cmt_valid),
        .out_ready (mdv_cmt_ready),
        .out_data  (mdv_cmt_data)
    );

    alu_commit_arb commit_arb_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .int_valid    (int_cmt_valid),
        .int_ready    (int_cmt_ready),
        .int_data     (int_cmt_data),
        .mdv_valid    (mdv_cmt_valid),
        .mdv_ready    (mdv_cmt_ready),
        .mdv_data     (mdv_cmt_data),
        .commit_valid (commit_valid),
        .commit_ready (commit_ready),
        .commit_data  (commit_data)
    );

endmodule

/* verification/alu_unit_tb.sv */
// Needs verification/alu_golden.txt reachable from the run directory; tags stay below 256
`timescale 1ns/100ps

module alu_unit_tb;
    import alu_pkg::*;

    localparam int max_vec = 64;
    localparam int min_vec = 19;
    localparam int timeout_cycles = 2000;

    logic                 clk;
    logic                 rst_n;
    logic                 in_valid;
    logic                 in_ready;
    alu_req_t             in_req;
    logic                 commit_valid;
    logic                 commit_ready;
    alu_commit_t          commit_data;
    logic                 branch_valid;
    branch_ctl_t          branch_ctl;

    // Golden vectors with one row per file line holding
    // op wid tmask rd pc imm rs1[4] rs2[4] exp[4] taken
    logic [31:0] vec [max_vec][19];
    int          num_vec;
    int          errors;
    int          tests_run;
    int          tests_failed;

    // Scoreboard indexed by tag and a queue of branch events in issue order
    logic        pending [256];
    int          vec_of  [256];
    int          outstanding;
    int          branch_q[$];
    logic        bp_enable;
    logic [31:0] lcg_state;
    int          ready_low_cycles;

    alu_unit alu_unit_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .in_req       (in_req),
        .commit_valid (commit_valid),
        .commit_ready (commit_ready),
        .commit_data  (commit_data),
        .branch_valid (branch_valid),
        .branch_ctl   (branch_ctl)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic is_branch_op(input int v);
        return vec[v][0] >= 32'd10 && vec[v][0] <= 32'd13;
    endfunction

    // Random back-pressure on the commit port when enabled
    always @(posedge clk) begin
        lcg_state <= lcg_next(lcg_state);
        commit_ready <= bp_enable ? lcg_state[27] : 1'b1;
    end

    // Commit and branch monitor
    always @(posedge clk) begin
        int v;
        logic [31:0] target;
        if (rst_n) begin
            if (!in_ready) begin
                ready_low_cycles++;
            end
            if (commit_valid && commit_ready) begin
                assert (pending[commit_data.tag]) else begin
                    $display("ERROR %0t: tag %0d committed but not pending", $time,
                             commit_data.tag);
                    errors++;
                end
                if (pending[commit_data.tag]) begin
                    v = vec_of[commit_data.tag];
                    pending[commit_data.tag] = 1'b0;
                    outstanding--;
                    assert (commit_data.tmask == vec[v][2][3:0] &&
                            commit_data.rd == vec[v][3][4:0] &&
                            commit_data.wid == vec[v][1][3:0] &&
                            commit_data.wb == !is_branch_op(v)) else begin
                        $display("ERROR %0t: tag %0d sideband mismatch", $time,
                                 commit_data.tag);
                        errors++;
                    end
                    for (int i = 0; i < num_lanes; i++) begin
                        if (vec[v][2][i] && !is_branch_op(v)) begin
                            assert (commit_data.data[i] == vec[v][14+i]) else begin
                                $display("ERROR %0t: tag %0d lane %0d got %h expected %h",
                                         $time, commit_data.tag, i, commit_data.data[i],
                                         vec[v][14+i]);
                                errors++;
                            end
                        end
                    end
                end
            end
            if (branch_valid) begin
                assert (branch_q.size() > 0) else begin
                    $display("ERROR %0t: branch pulse with no branch pending", $time);
                    errors++;
                end
                if (branch_q.size() > 0) begin
                    v = branch_q.pop_front();
                    target = vec[v][4] + vec[v][5];
                    assert (branch_ctl.taken == vec[v][18][0] &&
                            branch_ctl.target == target &&
                            branch_ctl.wid == vec[v][1][3:0]) else begin
                        $display("ERROR %0t: branch of vector %0d got taken %b target %h",
                                 $time, v, branch_ctl.taken, branch_ctl.target);
                        errors++;
                    end
                end
            end
        end
    end

    task automatic load_vectors();
        int fd;
        int n;
        string line;
        fd = $fopen("verification/alu_golden.txt", "r");
        if (fd == 0) begin
            $display("Could not open the golden vector file");
        end else begin
            while (!$feof(fd) && num_vec < max_vec) begin
                line = "";
                n = $fgets(line, fd);
                if (n > 1 && line[0] != "#") begin
                    n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        vec[num_vec][0], vec[num_vec][1], vec[num_vec][2], vec[num_vec][3],
                        vec[num_vec][4], vec[num_vec][5], vec[num_vec][6], vec[num_vec][7],
                        vec[num_vec][8], vec[num_vec][9], vec[num_vec][10], vec[num_vec][11],
                        vec[num_vec][12], vec[num_vec][13], vec[num_vec][14],
                        vec[num_vec][15], vec[num_vec][16], vec[num_vec][17],
                        vec[num_vec][18]);
                    if (n == 19) begin
                        num_vec++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic send_vec(input int v, input int tag);
        alu_req_t r;
        int waited;
        r.tag   = tag[7:0];
        r.wid   = vec[v][1][3:0];
        r.tmask = vec[v][2][3:0];
        r.op    = alu_op_e'(vec[v][0][4:0]);
        r.rd    = vec[v][3][4:0];
        r.pc    = vec[v][4];
        r.imm   = vec[v][5];
        for (int i = 0; i < num_lanes; i++) begin
            r.rs1[i] = vec[v][6+i];
            r.rs2[i] = vec[v][10+i];
        end
        pending[tag] = 1'b1;
        vec_of[tag]  = v;
        outstanding++;
        if (is_branch_op(v)) begin
            branch_q.push_back(v);
        end
        in_valid <= 1'b1;
        in_req   <= r;
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
        end while (!in_ready && waited < timeout_cycles);
        if (!in_ready) begin
            $display("Timed out waiting for in_ready on vector %0d", v);
            errors++;
        end
    endtask

    task automatic drain();
        int waited;
        in_valid <= 1'b0;
        waited = 0;
        while ((outstanding > 0 || branch_q.size() > 0) && waited < timeout_cycles) begin
            @(posedge clk);
            waited++;
        end
        if (outstanding > 0 || branch_q.size() > 0) begin
            $display("Timed out with %0d commits and %0d branches still missing",
                     outstanding, branch_q.size());
            errors++;
        end
    endtask

    task automatic run_range(input string name, input int first, input int last,
                             input int tag_base);
        int err_before;
        err_before = errors;
        for (int v = first; v <= last; v++) begin
            send_vec(v, tag_base + v);
        end
        drain();
        tests_run++;
        if (errors != err_before) begin
            tests_failed++;
        end
        $display("%s: %s", name, errors == err_before ? "ok" : "FAILED");
    endtask

    initial begin
        int err_before;
        clk = 1'b0;
        rst_n = 1'b0;
        in_valid = 1'b0;
        in_req = '0;
        commit_ready = 1'b1;
        bp_enable = 1'b0;
        lcg_state = 32'h723a_ab33;
        errors = 0;
        outstanding = 0;
        num_vec = 0;
        ready_low_cycles = 0;
        for (int t = 0; t < 256; t++) begin
            pending[t] = 1'b0;
        end
        load_vectors();

        err_before = errors;
        repeat (10) begin
            @(posedge clk);
            assert (in_ready && !commit_valid && !branch_valid) else begin
                $display("ERROR %0t: outputs not idle during reset", $time);
                errors++;
            end
        end
        rst_n <= 1'b1;
        @(posedge clk);
        assert (in_ready && !commit_valid && !branch_valid) else begin
            $display("ERROR %0t: outputs not idle after reset", $time);
            errors++;
        end
        tests_run++;
        if (errors != err_before) begin
            tests_failed++;
        end
        $display("reset state: %s", errors == err_before ? "ok" : "FAILED");

        if (num_vec < min_vec) begin
            $display("Only %0d golden vectors were read but %0d are needed", num_vec, min_vec);
            errors++;
        end else begin
            run_range("integer ops", 0, 9, 0);
            run_range("branches", 10, 13, 0);
            run_range("mul and div", 14, 17, 0);
            run_range("mixed traffic", 18, num_vec - 1, 0);

            bp_enable = 1'b1;
            ready_low_cycles = 0;
            run_range("back-pressure", 0, num_vec - 1, 128);
            bp_enable = 1'b0;

            err_before = errors;
            assert (ready_low_cycles > 0) else begin
                $display("ERROR %0t: in_ready never fell under back-pressure", $time);
                errors++;
            end
            tests_run++;
            if (errors != err_before) begin
                tests_failed++;
            end
            $display("in_ready under back-pressure: %s", errors == err_before ? "ok" : "FAILED");
        end

        $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* verification/alu_golden.txt */
# op wid tmask rd pc imm | rs1 lanes 0-3 | rs2 lanes 0-3 | expected lanes 0-3 | taken
# All fields hex; the row number is the request tag
0 1 f 3 0 0 1 2 ffffffff 7fffffff 1 3 1 1 2 5 0 80000000 0
1 1 f 4 0 0 5 0 80000000 10 3 1 1 10 2 ffffffff 7fffffff 0 0
2 2 5 5 0 0 ff f0f0 0 ffff f ff0 0 0 f f0 0 0 0
3 2 f 6 0 0 f0 1 0 8 f 2 0 1 ff 3 0 9 0
4 3 f 7 0 0 ff aaaa 1 0 f 5555 1 0 f0 ffff 0 0 0
5 3 f 8 0 0 1 1 3 ffffffff 4 1f 21 0 10 80000000 6 ffffffff 0
6 4 f 9 0 0 80000000 100 ffffffff 1 1f 4 10 0 1 10 ffff 1 0
7 4 f a 0 0 80000000 100 fffffff0 7fffffff 1f 4 2 1e ffffffff 10 fffffffc 1 0
8 5 f b 0 0 ffffffff 1 5 80000000 1 ffffffff 5 0 1 0 0 1 0
9 5 f c 0 0 ffffffff 1 5 0 1 ffffffff 6 0 0 1 1 0 0
a 6 e 0 100 20 1 7 0 0 2 7 1 1 0 0 0 0 1
b 6 f 0 200 fffffff0 5 1 1 1 5 2 2 2 0 0 0 0 0
c 7 8 0 40 8 0 0 0 ffffffff 0 0 0 1 0 0 0 0 1
d 7 c 0 0 4 9 9 80000000 0 0 0 1 0 0 0 0 0 0
e 8 f d 0 0 3 ffffffff 10000 7fffffff 5 2 10000 2 f fffffffe 0 fffffffe 0
f 8 f e 0 0 3 ffffffff 10000 80000000 5 2 10000 80000000 0 ffffffff 1 40000000 0
10 9 f f 0 0 14 ffffffec 80000000 7 3 3 ffffffff 0 6 fffffffa 80000000 ffffffff 0
11 9 f 10 0 0 14 ffffffec 80000000 7 3 3 ffffffff 0 2 fffffffe 0 7 0
10 a f 11 0 0 64 64 64 64 a 7 ffffffff 5 a e ffffff9c 14 0
0 a f 12 0 0 1 1 1 1 2 2 2 2 3 3 3 3 0
4 b f 13 0 0 f0f0 0 1 2 ffff 0 1 3 f0f 0 0 1 0
11 b f 14 0 0 64 65 66 67 7 7 7 7 2 3 4 5 0
a c 1 0 10 10 4 0 0 0 4 1 1 1 0 0 0 0 1
9 c f 15 0 0 0 1 2 3 2 2 2 2 1 1 0 0 0
e d f 16 0 0 fffffffd 4 0 1 7 4 5 1 ffffffeb 10 0 1 0

/* src.f */
src/alu_pkg.sv
src/alu_dispatch.sv
src/alu_int_unit.sv
src/alu_muldiv_unit.sv
src/alu_commit_arb.sv
src/alu_unit.sv
verification/alu_unit_tb.sv

/* Makefile */
VERILATOR ?= verilator
FILELIST  ?= src.f
TB_TOP    ?= alu_unit_tb
RTL_TOP   ?= alu_unit
BUILD_DIR ?= obj_dir
PASS_MSG  ?= Simulation passed
RTL_FILES ?= $(shell grep -v '^verification/' $(FILELIST))

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only --top-module $(RTL_TOP) $(RTL_FILES)

$(BUILD_DIR)/V$(TB_TOP): $(shell cat $(FILELIST))
	$(VERILATOR) --binary --timing --top-module $(TB_TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(BUILD_DIR)/V$(TB_TOP)
	@out="$$(./$(BUILD_DIR)/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
